//--- hdl/nes_bus_pkg.sv
package nes_bus_pkg;

    // CPU side address and data
    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  cpu_data_t;

    // Picture-processor register select, one of eight
    typedef logic [2:0]  ppu_reg_t;

    // Decoded address range
    typedef logic [1:0]  region_t;

    localparam region_t REGION_NONE = 2'd0;
    localparam region_t REGION_RAM  = 2'd1;
    localparam region_t REGION_PPU  = 2'd2;
    localparam region_t REGION_PRG  = 2'd3;

    // Range boundaries of the memory map
    // RAM below RAM_END, PPU registers below PPU_END, ROM from PRG_BASE up
    localparam cpu_addr_t RAM_END  = 16'h2000;
    localparam cpu_addr_t PPU_END  = 16'h4000;
    localparam cpu_addr_t PRG_BASE = 16'h8000;

    // 2 KB work RAM, mirrored four times in its window
    localparam int RAM_ADDR_W_DEF = 11;

    // Full 32 KB ROM window, a smaller image repeats across it
    localparam int PRG_ADDR_W_DEF = 15;

    // Status slot is fed from rendering, which lives elsewhere
    localparam ppu_reg_t PPU_STATUS_REG = 3'd2;

endpackage

//--- hdl/cpu_bus_if.sv
`timescale 1ns/100ps

interface cpu_bus_if import nes_bus_pkg::*; ();

    // Request side, one pulse per access
    logic      req_valid;
    cpu_addr_t addr;
    // 1 = read, 0 = write
    logic      rw;
    cpu_data_t wdata;

    // Completion side
    cpu_data_t rdata;
    logic      rd_valid;

    modport port (
        output req_valid, addr, rw, wdata,
        input  rdata, rd_valid
    );

    modport map (
        input  req_valid, addr, rw, wdata,
        output rdata, rd_valid
    );

endinterface

//--- hdl/target_if.sv
`timescale 1ns/100ps

interface target_if import nes_bus_pkg::*; #(
    parameter int ADDR_W = $bits(cpu_addr_t)
) ();

    // Chip select, high for one cycle per access
    logic              cs;

    // Address already folded to the target's own range
    logic [ADDR_W-1:0] addr;

    // 1 = read, 0 = write
    logic              rw;
    cpu_data_t         wdata;

    // Registered by the target, held until its next selected read
    cpu_data_t         rdata;

    modport map (
        output cs, addr, rw, wdata,
        input  rdata
    );

    modport target (
        input  cs, addr, rw, wdata,
        output rdata
    );

endinterface

//--- hdl/apb_cpu_port.sv
`timescale 1ns/100ps

module apb_cpu_port import nes_bus_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst_n,

    // APB slave pins
    input  logic      i_psel,
    input  logic      i_penable,
    input  logic      i_pwrite,
    input  cpu_addr_t i_paddr,
    input  cpu_data_t i_pwdata,
    output cpu_data_t o_prdata,
    output logic      o_pready,

    // Captured request toward the decoder
    cpu_bus_if.port   bus
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_DONE
    } state_t;

    state_t state;
    logic   setup;

    // Address and direction are already stable in the setup phase,
    // so the request leaves one cycle before the access phase starts
    assign setup = (state == ST_IDLE) && i_psel && !i_penable;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            state         <= ST_IDLE;
            bus.req_valid <= 1'b0;
            o_pready      <= 1'b0;
            o_prdata      <= '0;
        end
        else
        begin
            bus.req_valid <= 1'b0;
            o_pready      <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (setup)
                    begin
                        bus.req_valid <= 1'b1;
                        state         <= ST_BUSY;
                    end
                end
                ST_BUSY:
                begin
                    // Writes complete on rd_valid too, read data only on reads
                    if (bus.rd_valid)
                    begin
                        o_pready <= 1'b1;
                        if (bus.rw)
                            o_prdata <= bus.rdata;
                        state <= ST_DONE;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (setup)
        begin
            bus.addr  <= i_paddr;
            bus.rw    <= !i_pwrite;
            bus.wdata <= i_pwdata;
        end
    end

endmodule

//--- hdl/cpu_memory_map.sv
`timescale 1ns/100ps

module cpu_memory_map import nes_bus_pkg::*; #(
    parameter int RAM_ADDR_W = RAM_ADDR_W_DEF,
    parameter int PRG_ADDR_W = PRG_ADDR_W_DEF
) (
    input  logic   i_clk,
    input  logic   i_rst_n,

    cpu_bus_if.map bus,

    target_if.map  ram_bus,
    target_if.map  ppu_bus,
    target_if.map  prg_bus
);

    region_t   region;
    region_t   region_q;
    region_t   region_d;
    logic      sel_valid;
    logic      ret_valid;
    logic      rw_q;
    cpu_data_t wdata_q;

    // 0x4000-0x7FFF falls through as unmapped
    always_comb
    begin
        region = REGION_NONE;
        if (bus.addr < RAM_END)
            region = REGION_RAM;
        else if (bus.addr < PPU_END)
            region = REGION_PPU;
        else if (bus.addr >= PRG_BASE)
            region = REGION_PRG;
    end

    // Select stage, then one more stage aligned with the target access
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            ram_bus.cs <= 1'b0;
            ppu_bus.cs <= 1'b0;
            prg_bus.cs <= 1'b0;
            sel_valid  <= 1'b0;
            ret_valid  <= 1'b0;
            region_q   <= REGION_NONE;
            region_d   <= REGION_NONE;
        end
        else
        begin
            ram_bus.cs <= bus.req_valid && (region == REGION_RAM);
            ppu_bus.cs <= bus.req_valid && (region == REGION_PPU);
            prg_bus.cs <= bus.req_valid && (region == REGION_PRG);
            sel_valid  <= bus.req_valid;
            ret_valid  <= sel_valid;
            region_q   <= region;
            region_d   <= region_q;
        end
    end

    // Folded addresses give the mirroring of each window
    always_ff @(posedge i_clk)
    begin
        if (bus.req_valid)
        begin
            ram_bus.addr <= bus.addr[RAM_ADDR_W-1:0];
            ppu_bus.addr <= bus.addr[$bits(ppu_reg_t)-1:0];
            prg_bus.addr <= bus.addr[PRG_ADDR_W-1:0];
            rw_q         <= bus.rw;
            wdata_q      <= bus.wdata;
        end
    end

    assign ram_bus.rw    = rw_q;
    assign ppu_bus.rw    = rw_q;
    assign prg_bus.rw    = rw_q;
    assign ram_bus.wdata = wdata_q;
    assign ppu_bus.wdata = wdata_q;
    assign prg_bus.wdata = wdata_q;

    // Return path, unmapped reads give 0x00
    always_comb
    begin
        case (region_d)
            REGION_RAM: bus.rdata = ram_bus.rdata;
            REGION_PPU: bus.rdata = ppu_bus.rdata;
            REGION_PRG: bus.rdata = prg_bus.rdata;
            default:    bus.rdata = '0;
        endcase
    end

    assign bus.rd_valid = ret_valid;

endmodule

//--- hdl/work_ram.sv
`timescale 1ns/100ps

module work_ram import nes_bus_pkg::*; #(
    parameter int RAM_ADDR_W = RAM_ADDR_W_DEF
) (
    input  logic     i_clk,
    target_if.target bus
);

    localparam int DEPTH = 1 << RAM_ADDR_W;

    cpu_data_t mem [0:DEPTH-1];

    // Single port, read or write on the selected edge
    always_ff @(posedge i_clk)
    begin
        if (bus.cs)
        begin
            if (bus.rw)
            begin
                bus.rdata <= mem[bus.addr];
            end
            else
            begin
                mem[bus.addr] <= bus.wdata;
            end
        end
    end

endmodule

//--- hdl/prg_rom.sv
`timescale 1ns/100ps

module prg_rom import nes_bus_pkg::*; #(
    parameter int PRG_ADDR_W = PRG_ADDR_W_DEF
) (
    input  logic     i_clk,
    target_if.target bus
);

    localparam int DEPTH = 1 << PRG_ADDR_W;

    cpu_data_t rom [0:DEPTH-1];

    // Cartridge image, one hex byte per line
    initial
    begin
        $readmemh("prg_rom.hex", rom);
    end

    // Writes into the ROM window have no effect
    always_ff @(posedge i_clk)
    begin
        if (bus.cs && bus.rw)
        begin
            bus.rdata <= rom[bus.addr];
        end
    end

endmodule

//--- hdl/ppu_registers.sv
`timescale 1ns/100ps

module ppu_registers import nes_bus_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    target_if.target bus
);

    localparam int NUM_REGS = 1 << $bits(ppu_reg_t);

    cpu_data_t regs [0:NUM_REGS-1];
    ppu_reg_t  sel;

    assign sel = bus.addr;

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
            bus.rdata <= '0;
        end
        else if (bus.cs)
        begin
            if (bus.rw)
            begin
                // No status source here yet, so the slot reads back as zero
                if (sel == PPU_STATUS_REG)
                    bus.rdata <= '0;
                else
                    bus.rdata <= regs[sel];
            end
            else if (sel != PPU_STATUS_REG)
            begin
                regs[sel] <= bus.wdata;
            end
        end
    end

endmodule

//--- hdl/nes_cpu_bus_top.sv
`timescale 1ns/100ps

module nes_cpu_bus_top import nes_bus_pkg::*; #(
    parameter int RAM_ADDR_W = RAM_ADDR_W_DEF,
    parameter int PRG_ADDR_W = 5
) (
    input  logic      i_clk,
    input  logic      i_rst_n,

    input  logic      i_psel,
    input  logic      i_penable,
    input  logic      i_pwrite,
    input  cpu_addr_t i_paddr,
    input  cpu_data_t i_pwdata,
    output cpu_data_t o_prdata,
    output logic      o_pready
);

    cpu_bus_if cpu_bus ();

    target_if #(.ADDR_W(RAM_ADDR_W))        ram_bus ();
    target_if #(.ADDR_W($bits(ppu_reg_t))) ppu_bus ();
    target_if #(.ADDR_W(PRG_ADDR_W))        prg_bus ();

    apb_cpu_port u_apb_cpu_port (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .bus       (cpu_bus.port)
    );

    cpu_memory_map #(
        .RAM_ADDR_W (RAM_ADDR_W),
        .PRG_ADDR_W (PRG_ADDR_W)
    ) u_cpu_memory_map (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .bus     (cpu_bus.map),
        .ram_bus (ram_bus.map),
        .ppu_bus (ppu_bus.map),
        .prg_bus (prg_bus.map)
    );

    work_ram #(.RAM_ADDR_W(RAM_ADDR_W)) u_work_ram (
        .i_clk (i_clk),
        .bus   (ram_bus.target)
    );

    ppu_registers u_ppu_registers (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .bus     (ppu_bus.target)
    );

    prg_rom #(.PRG_ADDR_W(PRG_ADDR_W)) u_prg_rom (
        .i_clk (i_clk),
        .bus   (prg_bus.target)
    );

endmodule

//--- bench/nes_cpu_bus_assertions.sv
`timescale 1ns/100ps

module nes_cpu_bus_assertions (
    input logic       i_clk,
    input logic       i_rst_n,
    input logic       i_psel,
    input logic       i_penable,
    input logic       i_pready,
    input logic       i_req_valid,
    input logic [2:0] i_cs
);

    // Only one target may be selected in a cycle
    a_one_select: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(i_cs))
        else $error("more than one target select is high");

    // PREADY completes an access phase
    a_ready_in_access: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pready |-> (i_psel && i_penable))
        else $error("o_pready is high outside an access phase");

    a_ready_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_pready |=> !i_pready)
        else $error("o_pready is high for more than one cycle");

    // Selects are the registered form of a request
    a_select_after_request: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (|i_cs) |-> $past(i_req_valid))
        else $error("target select without a preceding req_valid");

endmodule

bind apb_cpu_port nes_cpu_bus_assertions u_port_checks (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pready    (o_pready),
    .i_req_valid (bus.req_valid),
    .i_cs        (3'b000)
);

// The decoder has no view of the APB pins
bind cpu_memory_map nes_cpu_bus_assertions u_map_checks (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_psel      (1'b0),
    .i_penable   (1'b0),
    .i_pready    (1'b0),
    .i_req_valid (bus.req_valid),
    .i_cs        ({ram_bus.cs, ppu_bus.cs, prg_bus.cs})
);

//--- bench/tb_nes_cpu_bus.sv
`timescale 1ns/100ps

module tb_nes_cpu_bus import nes_bus_pkg::*; ();

    typedef logic [7:0] wait_cnt_t;

    localparam int        RAM_WRITES = 48;
    localparam wait_cnt_t EXP_WAITS  = 8'd3;
    // Reset reads, RAM, PPU, ROM, then unmapped accesses with their rechecks
    localparam int        NUM_TRANSFERS = 8 + 2 * RAM_WRITES + 24 + 40 + 32 + RAM_WRITES + 16;
    localparam real       WATCHDOG_NS   = NUM_TRANSFERS * 6 * 100.0 + 12 * 100.0;

    logic      i_clk;
    logic      i_rst_n;
    logic      i_psel;
    logic      i_penable;
    logic      i_pwrite;
    cpu_addr_t i_paddr;
    cpu_data_t i_pwdata;
    cpu_data_t o_prdata;
    logic      o_pready;

    // Shadow state of the memory map
    cpu_data_t ram_shadow [0:2047];
    cpu_data_t ppu_shadow [0:7];
    cpu_data_t prg_image  [0:31];
    cpu_addr_t ram_addrs  [$];

    // Completed transfers waiting for comparison
    cpu_addr_t addr_q [$];
    cpu_data_t got_q  [$];
    cpu_data_t exp_q  [$];
    wait_cnt_t wait_q [$];

    nes_cpu_bus_top u_nes_cpu_bus_top (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready)
    );

    always #50 i_clk = ~i_clk;

    function automatic cpu_data_t expected_read(cpu_addr_t addr);
        if (addr < 16'h2000)
            return ram_shadow[addr[10:0]];
        if (addr < 16'h4000)
        begin
            // Status slot has no source and reads as zero
            if (addr[2:0] == 3'd2)
                return 8'h00;
            return ppu_shadow[addr[2:0]];
        end
        if (addr < 16'h8000)
            return 8'h00;
        return prg_image[addr[4:0]];
    endfunction

    function automatic void model_write(cpu_addr_t addr, cpu_data_t data);
        if (addr < 16'h2000)
            ram_shadow[addr[10:0]] = data;
        else if (addr < 16'h4000 && addr[2:0] != 3'd2)
            ppu_shadow[addr[2:0]] = data;
    endfunction

    task automatic compare_data(string name, cpu_data_t got, cpu_data_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Testbench failed");
            $fatal(1, "Read data mismatch");
        end
    endtask

    task automatic compare_waits(wait_cnt_t got, wait_cnt_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] o_pready wait cycles: got 0x%h, expected 0x%h", got, exp);
            $display("Testbench failed");
            $fatal(1, "Wait state mismatch");
        end
    endtask

    // Called on a falling edge, returns on the falling edge after completion
    task automatic apb_transfer(input logic write, input cpu_addr_t addr,
                                input cpu_data_t wdata, output cpu_data_t rdata,
                                output wait_cnt_t waits);
        int cycles;
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = write;
        i_paddr   = addr;
        i_pwdata  = wdata;
        @(negedge i_clk);
        i_penable = 1'b1;
        cycles    = 0;
        while (!o_pready)
        begin
            @(negedge i_clk);
            cycles++;
        end
        rdata = o_prdata;
        waits = wait_cnt_t'(cycles);
        @(negedge i_clk);
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    task automatic write_byte(cpu_addr_t addr, cpu_data_t data);
        cpu_data_t unused;
        wait_cnt_t waits;
        apb_transfer(1'b1, addr, data, unused, waits);
        wait_q.push_back(waits);
        model_write(addr, data);
    endtask

    task automatic read_byte(cpu_addr_t addr);
        cpu_data_t got;
        wait_cnt_t waits;
        apb_transfer(1'b0, addr, 8'h00, got, waits);
        wait_q.push_back(waits);
        addr_q.push_back(addr);
        got_q.push_back(got);
        exp_q.push_back(expected_read(addr));
    endtask

    always @(negedge i_clk)
    begin
        while (wait_q.size() > 0)
            compare_waits(wait_q.pop_front(), EXP_WAITS);
        while (got_q.size() > 0)
            compare_data($sformatf("o_prdata @ 0x%h", addr_q.pop_front()),
                         got_q.pop_front(), exp_q.pop_front());
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0.0f ns", WATCHDOG_NS);
        $display("Testbench failed");
        $fatal(1, "Watchdog expired");
    end

    initial
    begin
        cpu_addr_t addr;
        void'($urandom(32'hac7d));
        $readmemh("prg_rom.hex", prg_image);
        for (int i = 0; i < 8; i++)
            ppu_shadow[i] = 8'h00;
        i_clk     = 1'b0;
        i_rst_n   = 1'b0;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = '0;
        i_pwdata  = '0;
        repeat (10) @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);
        if (o_pready !== 1'b0)
        begin
            $display("[ERROR] o_pready after reset: got 0x%h, expected 0x0", o_pready);
            $display("Testbench failed");
            $fatal(1, "Reset state");
        end
        compare_data("o_prdata after reset", o_prdata, 8'h00);

        // PPU registers come out of reset cleared
        for (int i = 0; i < 8; i++)
            read_byte(16'h2000 + cpu_addr_t'(i));

        // RAM writes are read back through a random one of the four mirrors
        for (int i = 0; i < RAM_WRITES; i++)
        begin
            addr = cpu_addr_t'($urandom_range(16'h1fff, 0));
            ram_addrs.push_back(addr);
            write_byte(addr, cpu_data_t'($urandom()));
        end
        foreach (ram_addrs[i])
            read_byte({3'b000, 2'($urandom_range(3, 0)), ram_addrs[i][10:0]});

        // Every register is written twice through random mirrors, status slot included
        for (int i = 0; i < 16; i++)
            write_byte({3'b001, 10'($urandom_range(1023, 0)), 3'(i)},
                       cpu_data_t'($urandom()));
        for (int i = 0; i < 8; i++)
            read_byte({3'b001, 10'($urandom_range(1023, 0)), 3'(i)});

        // ROM image repeats every 32 bytes and ignores writes
        for (int i = 0; i < 32; i++)
            read_byte(16'h8000 | cpu_addr_t'($urandom_range(16'h7fff, 0)));
        for (int i = 0; i < 4; i++)
        begin
            addr = 16'h8000 | cpu_addr_t'($urandom_range(16'h7fff, 0));
            write_byte(addr, ~expected_read(addr));
            read_byte(addr);
        end

        // Unmapped writes alias written RAM locations in their low bits
        for (int i = 0; i < 16; i++)
            read_byte(16'h4000 | cpu_addr_t'($urandom_range(16'h3fff, 0)));
        for (int i = 0; i < 16; i++)
            write_byte({2'b01, 3'($urandom_range(7, 0)), ram_addrs[i][10:0]},
                       cpu_data_t'($urandom()));
        foreach (ram_addrs[i])
            read_byte(ram_addrs[i]);
        for (int i = 0; i < 8; i++)
            read_byte(16'h2000 + cpu_addr_t'(i));
        for (int i = 0; i < 8; i++)
            read_byte(16'h8000 + cpu_addr_t'(i * 16'h1001));

        repeat (2) @(negedge i_clk);
        if (got_q.size() != 0 || wait_q.size() != 0)
        begin
            $display("Some transfers were left without a comparison");
            $display("Testbench failed");
            $fatal(1, "Unchecked results");
        end
        else
        begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

//--- prg_rom.hex
// One hex byte per line, line order is the ROM offset 0x00 to 0x1F
78
D8
A2
FF
9A
AD
02
20
10
FB
A9
80
8D
00
20
A9
1E
8D
01
20
4C
14
80
EA
EA
40
19
80
00
80
19
80

//--- project.f
hdl/nes_bus_pkg.sv
hdl/cpu_bus_if.sv
hdl/target_if.sv
hdl/apb_cpu_port.sv
hdl/cpu_memory_map.sv
hdl/work_ram.sv
hdl/prg_rom.sv
hdl/ppu_registers.sv
hdl/nes_cpu_bus_top.sv
bench/nes_cpu_bus_assertions.sv
bench/tb_nes_cpu_bus.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module tb_nes_cpu_bus -f project.f &&
    ./obj_dir/Vtb_nes_cpu_bus ||
    { echo "Simulation did not complete successfully"; exit 1; }
